// ==== Makefile ====
# Verilator build and run of the pixel uplink testbench, run from the project root

VERILATOR ?= verilator
TOP       ?= pixel_uplink_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= PASS: all tests

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and the variables"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/frame_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

// walks the frame store in address order after start
// each pixel goes to the sender as a one cycle request and the next one waits for done
module frame_reader import pixel_link_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,                // one cycle pulse, only seen while idle
    output addr_t      rd_addr,              // store read address
    input  pixel_t     rd_pixel,             // store data, one cycle after rd_addr
    output pixel_req_t req,                  // pixel request to the sender
    input  logic       done,                 // sender has finished the last request
    output logic       busy                  // a frame is being sent
);

    reader_state_t state;
    addr_t         addr_q;                   // address of the pixel in progress
    logic          last_pixel;               // addr_q is the final location of the frame

    assign last_pixel = (addr_q == addr_t'(FRAME_PIXELS - 1));

    assign rd_addr = addr_q;
    assign busy    = (state != idle);        // start is ignored for as long as this is high

    // the store output is already registered, so the request is formed straight from it
    always_comb begin
        req.valid = (state == issue);
        req.pixel = rd_pixel;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= idle;
            addr_q <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        addr_q <= '0;            // every frame begins at the first pixel
                        state  <= fetch;
                    end
                end
                fetch: begin
                    state <= issue;              // read data lands at this edge
                end
                issue: begin
                    state <= wait_done;          // strobe was up for this single cycle
                end
                wait_done: begin
                    if (done) begin
                        if (last_pixel) begin
                            state <= idle;       // frame complete and busy falls
                        end else begin
                            addr_q <= addr_q + addr_t'(1);
                            state  <= fetch;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_store.sv ====
`timescale 1ns/1ps
`default_nettype none

// single clock pixel memory with a host write port and a registered read port
// contents come only from host writes
module frame_store import pixel_link_pkg::*; (
    input  logic   clk,
    input  logic   wr_en,                    // host write strobe
    input  addr_t  wr_addr,                  // host write address
    input  pixel_t wr_pixel,                 // pixel written at wr_addr
    input  addr_t  rd_addr,                  // read address from the reader
    output pixel_t rd_pixel                  // data for rd_addr, one cycle later
);

    pixel_t mem [FRAME_PIXELS];              // one location per pixel of the frame

    // host side, one pixel per enabled edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_pixel;
        end
    end

    // the read is registered so the reader sees the pixel one cycle after the address
    always_ff @(posedge clk) begin
        rd_pixel <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== design/pixel_link_pkg.sv ====
`default_nettype none

// widths, types and constants shared by the pixel uplink modules
package pixel_link_pkg;

    typedef logic [11:0] pixel_t;            // one picture element as the host writes it
    typedef logic [7:0]  byte_t;             // one byte on the serial line
    typedef logic [3:0]  addr_t;             // frame store address, wide enough for a whole frame

    localparam int FRAME_PIXELS = 16;        // pixels per frame, one per store location

    // bit period for a 50 MHz clock at 9600 baud
    localparam int DEFAULT_CLKS_PER_BIT = 50_000_000 / 9600;

    localparam int BIT_TIMER_W = 16;         // enough for any bit period up to 65535 clocks
    typedef logic [BIT_TIMER_W-1:0] bit_timer_t;

    // scan sequence of the frame reader
    typedef enum logic [1:0] {
        idle,                                // waiting for start with busy low
        fetch,                               // address is on the store, data comes back next cycle
        issue,                               // read data is valid and goes out as a request
        wait_done                            // sender is busy with the pixel
    } reader_state_t;

    // one cycle pixel request from the reader to the sender
    typedef struct packed {
        logic   valid;                       // strobe, high for exactly one cycle
        pixel_t pixel;                       // pixel value that goes with the strobe
    } pixel_req_t;

endpackage

`default_nettype wire

// ==== design/pixel_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

// sends one 12-bit pixel as two UART bytes
// the high byte carries pixel bits 11 to 4 and the low byte is four zeros then bits 3 to 0
module pixel_sender import pixel_link_pkg::*; #(
    parameter int clks_per_bit = DEFAULT_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       rst,
    input  pixel_req_t req,                  // one cycle request from the reader
    output logic       done,                 // one cycle pulse after the low byte's stop bit
    output logic       uart_out              // serial line
);

    logic       sending;                     // a pixel is being worked on
    logic [1:0] byte_idx;                    // bytes accepted by the UART so far, 0 to 2
    pixel_t     pixel_q;                     // captured pixel, stable while both bytes go out
    byte_t      high_byte;
    byte_t      low_byte;
    byte_t      tx_byte;                     // byte that byte_idx selects for the UART
    logic       uart_valid;
    logic       uart_ready;

    always_comb begin
        high_byte = pixel_q[11:4];
        low_byte  = {4'b0000, pixel_q[3:0]};        // upper nibble is padding
        tx_byte   = byte_idx[0] ? low_byte : high_byte;
    end

    // valid stays up with the same byte until the UART takes it
    assign uart_valid = sending && (byte_idx != 2'd2);

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) u_uart_tx (
        .clk     (clk),
        .rst     (rst),
        .data    (tx_byte),
        .valid   (uart_valid),
        .ready   (uart_ready),
        .uart_out(uart_out)
    );

    // byte sequencing and the done pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            sending  <= 1'b0;
            byte_idx <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;                            // done lasts one cycle only
            if (!sending) begin
                if (req.valid) begin
                    sending  <= 1'b1;
                    byte_idx <= '0;                  // high byte goes first
                end
            end else if (uart_valid && uart_ready) begin
                byte_idx <= byte_idx + 2'd1;         // advance on every acceptance
            end else if (byte_idx == 2'd2 && uart_ready) begin
                // ready drops the cycle after acceptance so this waits out the low byte's frame
                sending <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    // the pixel is payload and is only loaded with a new request
    always_ff @(posedge clk) begin
        if (!sending && req.valid) begin
            pixel_q <= req.pixel;
        end
    end

endmodule

`default_nettype wire

// ==== design/pixel_uplink_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// picture uplink from the frame store through the reader and sender to the serial line
module pixel_uplink_top import pixel_link_pkg::*; #(
    parameter int clks_per_bit = DEFAULT_CLKS_PER_BIT
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   wr_en,
    input  addr_t  wr_addr,
    input  pixel_t wr_pixel,
    input  logic   start,                    // begins a frame when busy is low
    output logic   busy,                     // falls after the last byte's stop bit
    output logic   uart_out
);

    addr_t      rd_addr;
    pixel_t     rd_pixel;
    pixel_req_t req;                         // reader to sender strobe with its pixel
    logic       done;                        // sender back to reader

    frame_store u_frame_store (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_pixel(wr_pixel),
        .rd_addr (rd_addr),
        .rd_pixel(rd_pixel)
    );

    frame_reader u_frame_reader (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .rd_addr (rd_addr),
        .rd_pixel(rd_pixel),
        .req     (req),
        .done    (done),
        .busy    (busy)
    );

    pixel_sender #(
        .clks_per_bit(clks_per_bit)
    ) u_pixel_sender (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .done    (done),
        .uart_out(uart_out)
    );

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

// 8N1 transmitter with a start bit, eight data bits sent lsb first and one stop bit
// a byte is taken on the edge where valid and ready are both high
module uart_tx import pixel_link_pkg::*; #(
    parameter int clks_per_bit = DEFAULT_CLKS_PER_BIT
) (
    input  logic  clk,
    input  logic  rst,
    input  byte_t data,                      // byte to send, held by the source until accepted
    input  logic  valid,                     // source has a byte for us
    output logic  ready,                     // high while idle, low for the whole frame
    output logic  uart_out                   // serial line, idles high
);

    logic       active;                      // a frame is on the line
    bit_timer_t bit_timer;                   // clocks spent in the current bit
    logic [3:0] bit_count;                   // which of the ten frame bits is on the line
    logic [9:0] shift_q;                     // stop bit, data and start bit, lsb goes out first
    logic       accept;                      // handshake completes on this edge
    logic       bit_end;                     // last clock of the current bit period

    assign accept  = valid && !active;
    assign bit_end = (bit_timer == bit_timer_t'(clks_per_bit - 1));

    assign ready = !active;

    // the line is forced high between frames so reset alone gives an idle line
    assign uart_out = active ? shift_q[0] : 1'b1;

    // frame control with the bit timer and bit counter
    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            bit_timer <= '0;
            bit_count <= '0;
        end else if (!active) begin
            if (accept) begin
                active    <= 1'b1;               // start bit goes out from the next cycle
                bit_timer <= '0;
                bit_count <= '0;
            end
        end else if (bit_end) begin
            bit_timer <= '0;
            if (bit_count == 4'd9) begin
                active <= 1'b0;                  // stop bit has run its full period
            end else begin
                bit_count <= bit_count + 4'd1;
            end
        end else begin
            bit_timer <= bit_timer + bit_timer_t'(1);
        end
    end

    // the shift register only carries the payload so it follows accept and the bit timer
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= {1'b1, data, 1'b0};       // stop, data, start
        end else if (active && bit_end) begin
            shift_q <= {1'b1, shift_q[9:1]};     // next bit moves down to the line
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/pixel_link_pkg.sv
design/uart_tx.sv
design/frame_store.sv
design/frame_reader.sv
design/pixel_sender.sv
design/pixel_uplink_top.sv
sim/pixel_uplink_tb.sv

// ==== sim/pixel_stimulus.txt ====
// columns: pixel, expected high byte (pixel bits 11 to 4), expected low byte (0 then bits 3 to 0)
// one line per frame store address, in address order, the tag names the address
000 00 00 // addr 0
fff ff 0f // addr 1
a5c a5 0c // addr 2
123 12 03 // addr 3
800 80 00 // addr 4
001 00 01 // addr 5
7e9 7e 09 // addr 6
3c4 3c 04 // addr 7
5a5 5a 05 // addr 8
f0f f0 0f // addr 9
0f0 0f 00 // addr 10
9b7 9b 07 // addr 11
246 24 06 // addr 12
c3d c3 0d // addr 13
6e2 6e 02 // addr 14
b18 b1 08 // addr 15

// ==== sim/pixel_uplink_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// drives two frames through the uplink and decodes the serial line bit by bit
module pixel_uplink_tb import pixel_link_pkg::*; ();

    localparam int CPB = 4;                   // short bit period keeps the run small
    localparam int FRAME_BYTES = 2 * FRAME_PIXELS;
    // two frames of ten bit periods per byte, the margin covers handshake gaps and the writes
    localparam int MAX_CYCLES = 2 * FRAME_BYTES * 10 * CPB + 1000;
    localparam logic [31:0] SEED = 32'h4311_d813;

    logic   clk;
    logic   rst;
    logic   wr_en;
    addr_t  wr_addr;
    pixel_t wr_pixel;
    logic   start;
    logic   busy;
    logic   uart_out;

    logic [11:0] stim_mem [3 * FRAME_PIXELS];  // pixel, high byte, low byte per address
    byte_t       exp_q [$];                    // bytes still expected on the line
    integer      seed;
    int          value_errors;
    int          other_errors;
    int          byte_count;                   // bytes decoded in the current frame
    int          cycle_count = 0;

    pixel_uplink_top #(
        .clks_per_bit(CPB)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_pixel(wr_pixel),
        .start   (start),
        .busy    (busy),
        .uart_out(uart_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                 // 8 ns period
    end

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("[FAIL] %0t ns: %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        value_errors++;
    endtask

    task automatic flag_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        other_errors++;
    endtask

    task automatic skip_cycles(input int n);
        repeat (n) @(negedge clk);             // outputs are looked at away from the rising edge
    endtask

    task automatic write_pixel(input addr_t addr, input pixel_t value);
        @(posedge clk);
        wr_en    <= 1'b1;
        wr_addr  <= addr;
        wr_pixel <= value;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // sends one frame and checks its length, the fall of busy and the quiet line afterwards
    task automatic run_frame(input bit poke_start);
        byte_count = 0;
        pulse_start();
        @(negedge clk);
        assert (busy === 1'b1) else flag_problem("busy did not rise after the start pulse");
        if (poke_start) begin
            skip_cycles(50 * CPB);             // well into the third pixel, a restart would resend
            pulse_start();                     // must be ignored while busy
        end
        while (busy === 1'b1) @(negedge clk);  // the global cycle limit catches a stuck frame
        assert (byte_count == FRAME_BYTES)
            else flag_mismatch("byte count", 32'(FRAME_BYTES), 32'(byte_count));
        assert (exp_q.size() == 0) else flag_problem("busy fell before all bytes were sent");
        repeat (4 * CPB) begin
            @(negedge clk);
            assert (uart_out === 1'b1) else flag_mismatch("uart_out", 32'd1, 32'(uart_out));
        end
        assert (byte_count == FRAME_BYTES) else flag_problem("bytes appeared after busy fell");
    endtask

    // serial decoder, samples each bit near the middle of its period
    initial begin : serial_monitor
        byte_t got;
        byte_t want;
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (uart_out === 1'b0) begin
                skip_cycles(CPB / 2 - 1);      // middle of the start bit
                assert (uart_out === 1'b0)
                    else flag_mismatch("start bit", 32'd0, 32'(uart_out));
                for (int i = 0; i < 8; i++) begin
                    skip_cycles(CPB);
                    got[i] = uart_out;         // lsb arrives first
                end
                skip_cycles(CPB);
                assert (uart_out === 1'b1)
                    else flag_mismatch("stop bit", 32'd1, 32'(uart_out));
                byte_count++;
                if (exp_q.size() == 0) begin
                    flag_problem($sformatf("unexpected extra byte 0x%0h on uart_out", got));
                end else begin
                    want = exp_q.pop_front();
                    assert (got == want) else flag_mismatch("uart_out byte", 32'(want), 32'(got));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin : main_sequence
        pixel_t pix;
        rst          <= 1'b1;
        wr_en        <= 1'b0;
        wr_addr      <= '0;
        wr_pixel     <= '0;
        start        <= 1'b0;
        seed         = SEED;
        value_errors = 0;
        other_errors = 0;
        byte_count   = 0;
        $readmemh("sim/pixel_stimulus.txt", stim_mem);
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // idle line and no frame before any start
        skip_cycles(3);
        assert (uart_out === 1'b1) else flag_mismatch("uart_out", 32'd1, 32'(uart_out));
        assert (busy === 1'b0) else flag_mismatch("busy", 32'd0, 32'(busy));

        // first frame from the data file, with a stray start while busy
        for (int a = 0; a < FRAME_PIXELS; a++) begin
            write_pixel(addr_t'(a), pixel_t'(stim_mem[3 * a]));
            exp_q.push_back(byte_t'(stim_mem[3 * a + 1]));
            exp_q.push_back(byte_t'(stim_mem[3 * a + 2]));
        end
        @(posedge clk);
        wr_en <= 1'b0;
        run_frame(1'b1);

        // second frame overwrites every location with random pixels
        for (int a = 0; a < FRAME_PIXELS; a++) begin
            pix = pixel_t'($random(seed));
            write_pixel(addr_t'(a), pix);
            exp_q.push_back(pix[11:4]);                // high byte
            exp_q.push_back({4'b0000, pix[3:0]});      // low byte is padded with zeros
        end
        @(posedge clk);
        wr_en <= 1'b0;
        run_frame(1'b0);

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
